//--- api_cfg_pkg.sv
package api_cfg_pkg;

	// chain and data path sizes.
	localparam int api_num = 8;
	localparam int work_len = 23; // words per reply block.
	localparam int rx_block_len = 11; // words kept per block.
	localparam int max_chip_in_ch = 5;
	localparam int tx_depth = 64;
	localparam int rx_depth = 64;
	localparam logic [7:0] tag_marker = 8'h12;

	typedef logic [31:0] word_t;
	typedef logic [27:0] timeout_t;
	typedef logic [7:0] sck_div_t;
	typedef logic [5:0] ch_t;
	typedef logic [7:0] word_cnt_t;
	typedef logic [6:0] fifo_cnt_t; // counts up to 64.

	typedef enum logic [1:0] {
		idle = 2'd0,
		work = 2'd1,
		nop = 2'd2,
		done = 2'd3
	} ctrl_state_t;

endpackage

//--- api_reg_pkg.sv
package api_reg_pkg;

	typedef logic [7:0] addr_t;

	localparam addr_t reg_timeout_addr = 8'h00;
	localparam addr_t reg_sck_addr = 8'h04;
	localparam addr_t reg_ch_num_addr = 8'h08;
	localparam addr_t reg_word_num_addr = 8'h0C;
	localparam addr_t reg_tx_data_addr = 8'h10;
	localparam addr_t reg_rx_data_addr = 8'h14;
	localparam addr_t reg_status_addr = 8'h18;

	// status word fields.
	localparam int status_state_lsb = 0;
	localparam int status_state_msb = 1;
	localparam int status_tx_empty_bit = 4;
	localparam int status_rx_count_lsb = 8;
	localparam int status_rx_count_msb = 14;

endpackage

//--- api_fifo.sv
`timescale 1ns/1ns

module api_fifo #(
	parameter int depth = 64
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input api_cfg_pkg::word_t din,
	input logic rd_en,
	output api_cfg_pkg::word_t dout,
	output logic full,
	output logic empty,
	output api_cfg_pkg::fifo_cnt_t count
);
	import api_cfg_pkg::*;

	typedef logic [$clog2(depth)-1:0] ptr_t;

	word_t mem [depth];
	ptr_t wr_ptr;
	ptr_t rd_ptr;

	assign dout = mem[rd_ptr]; // head word falls through.
	assign full = (count == fifo_cnt_t'(depth));
	assign empty = (count == '0);

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + fifo_cnt_t'(wr_en) - fifo_cnt_t'(rd_en);
		end
	end

	assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);
	assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty);

endmodule

//--- api_timer.sv
`timescale 1ns/1ns

module api_timer (
	input logic clk,
	input logic rst,
	input api_cfg_pkg::timeout_t reg_timeout,
	input logic start,
	output logic busy
);
	import api_cfg_pkg::*;

	timeout_t cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (start) begin
			cnt <= reg_timeout; // restart reloads.
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign busy = (cnt != '0);

endmodule

//--- api_phy.sv
`timescale 1ns/1ns

module api_phy (
	input logic clk,
	input logic rst,
	input api_cfg_pkg::sck_div_t sck_div,
	input logic mosi_vld,
	input api_cfg_pkg::word_t mosi_dat,
	output logic miso_vld,
	output api_cfg_pkg::word_t miso_dat,
	output logic sck,
	output logic mosi,
	input logic miso
);
	import api_cfg_pkg::*;

	logic busy;
	sck_div_t div_cnt;
	logic [5:0] edge_cnt; // 64 sck edges per word.
	logic tick;
	word_t tx_sr;
	word_t rx_sr;

	assign tick = busy && (div_cnt == sck_div);
	assign miso_vld = tick && (edge_cnt == 6'd63); // last falling edge.
	assign miso_dat = rx_sr;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			div_cnt <= '0;
			edge_cnt <= '0;
			sck <= 1'b0;
			mosi <= 1'b0;
		end else if (mosi_vld) begin
			busy <= 1'b1;
			div_cnt <= '0;
			edge_cnt <= '0;
			sck <= 1'b0;
			mosi <= mosi_dat[31]; // msb first.
		end else if (tick) begin
			div_cnt <= '0;
			edge_cnt <= edge_cnt + 1'b1;
			sck <= ~sck;
			if (sck)
				mosi <= tx_sr[30];
			if (miso_vld)
				busy <= 1'b0;
		end else if (busy) begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// shift out on falling sck, sample on rising sck.
	always_ff @(posedge clk) begin
		if (mosi_vld) begin
			tx_sr <= mosi_dat;
		end else if (tick && sck) begin
			tx_sr <= {tx_sr[30:0], 1'b0};
		end else if (tick) begin
			rx_sr <= {rx_sr[30:0], miso};
		end
	end

	assert property (@(posedge clk) disable iff (rst) mosi_vld |-> !busy);

endmodule

//--- api_ctrl.sv
`timescale 1ns/1ns

module api_ctrl (
	input logic clk,
	input logic rst,
	input api_cfg_pkg::timeout_t reg_timeout,
	input api_cfg_pkg::sck_div_t reg_sck,
	input api_cfg_pkg::ch_t reg_ch_num,
	input api_cfg_pkg::word_cnt_t reg_word_num,
	output api_cfg_pkg::ctrl_state_t state,
	input logic tx_empty,
	output logic tx_rd_en,
	input api_cfg_pkg::word_t tx_dout,
	output logic rx_wr_en,
	output api_cfg_pkg::word_t rx_din,
	input api_cfg_pkg::fifo_cnt_t rx_count,
	output logic [api_cfg_pkg::api_num-1:0] load,
	output logic sck,
	output logic mosi,
	input logic [api_cfg_pkg::api_num-1:0] miso
);
	import api_cfg_pkg::*;

	ctrl_state_t nxt_state;
	ch_t ch_cnt; // channels opened this round.
	ch_t ch_idx;
	word_cnt_t word_cnt;
	word_cnt_t blk_idx; // word index inside the reply block.
	logic [3:0] nop_cnt;
	logic settled;
	logic in_flight;
	logic trail_sent;
	logic rx_space_ok;
	logic enter_work;
	logic timer_start;
	logic timer_busy;
	logic send_work;
	logic send_trail;
	logic mosi_vld;
	word_t mosi_dat;
	logic miso_vld;
	word_t miso_dat;
	logic miso_bit;

	assign rx_space_ok = (rx_depth - int'(rx_count)) >= (rx_block_len * max_chip_in_ch);
	assign settled = (nop_cnt == 4'd14);
	assign enter_work = (state != work) && (nxt_state == work);
	assign timer_start = (state == idle) && (nxt_state != idle);

	always_comb begin
		nxt_state = state;
		case (state)
			idle: if (!tx_empty && rx_space_ok) nxt_state = work;
			work: if (word_cnt == reg_word_num) nxt_state = nop;
			nop: begin
				if (settled && ch_cnt == reg_ch_num)
					nxt_state = done;
				else if (settled && !tx_empty && rx_space_ok)
					nxt_state = work;
			end
			done: if (!timer_busy && trail_sent && !in_flight) nxt_state = idle;
			default: nxt_state = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			ch_cnt <= '0;
			nop_cnt <= '0;
			in_flight <= 1'b0;
			trail_sent <= 1'b0;
			load <= '1;
		end else begin
			state <= nxt_state;
			if (nxt_state == idle)
				ch_cnt <= '0;
			else if (enter_work)
				ch_cnt <= ch_cnt + 1'b1;
			if (state != nop)
				nop_cnt <= '0;
			else if (!settled)
				nop_cnt <= nop_cnt + 1'b1;
			if (mosi_vld)
				in_flight <= 1'b1;
			else if (miso_vld)
				in_flight <= 1'b0;
			if (nxt_state == idle)
				trail_sent <= 1'b0;
			else if (send_trail)
				trail_sent <= 1'b1;
			if (enter_work)
				load <= ~(api_num'(1) << ch_cnt); // next chip low.
			else if (state == work && nxt_state == nop)
				load <= '1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			word_cnt <= '0;
			blk_idx <= '0;
		end else if (enter_work) begin
			word_cnt <= '0;
			blk_idx <= '0;
		end else if (state == work && miso_vld) begin
			word_cnt <= word_cnt + 1'b1;
			blk_idx <= (blk_idx == word_cnt_t'(work_len - 1)) ? '0 : blk_idx + 1'b1;
		end
	end

	// one word in flight at a time.
	assign send_work = (state == work) && !in_flight && !tx_empty && (word_cnt != reg_word_num);
	assign send_trail = (state == done) && !in_flight && !trail_sent;
	assign mosi_vld = send_work || send_trail;
	assign mosi_dat = send_work ? tx_dout : '0; // trailing word carries no job.
	assign tx_rd_en = send_work;

	assign ch_idx = ch_cnt - 1'b1;
	assign rx_wr_en = (state == work) && miso_vld && (blk_idx < word_cnt_t'(rx_block_len));
	assign rx_din = (blk_idx == word_cnt_t'(rx_block_len - 1)) ?
		{miso_dat[31:16], tag_marker, 8'(ch_idx)} : miso_dat;

	assign miso_bit = &(miso | load); // unselected chips read as one.

	api_timer api_timer_inst (
		.clk(clk),
		.rst(rst),
		.reg_timeout(reg_timeout),
		.start(timer_start),
		.busy(timer_busy)
	);

	api_phy api_phy_inst (
		.clk(clk),
		.rst(rst),
		.sck_div(reg_sck),
		.mosi_vld(mosi_vld),
		.mosi_dat(mosi_dat),
		.miso_vld(miso_vld),
		.miso_dat(miso_dat),
		.sck(sck),
		.mosi(mosi),
		.miso(miso_bit)
	);

	// a chip is selected only while a channel is in work.
	assert property (@(posedge clk) disable iff (rst)
		$countones(~load) <= ((state == work) ? 1 : 0));
	assert property (@(posedge clk) disable iff (rst)
		rx_wr_en |-> rx_count != fifo_cnt_t'(rx_depth));

endmodule

//--- api_regs.sv
`timescale 1ns/1ns

module api_regs (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input api_reg_pkg::addr_t paddr,
	input api_cfg_pkg::word_t pwdata,
	output api_cfg_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	output api_cfg_pkg::timeout_t reg_timeout,
	output api_cfg_pkg::sck_div_t reg_sck,
	output api_cfg_pkg::ch_t reg_ch_num,
	output api_cfg_pkg::word_cnt_t reg_word_num,
	input api_cfg_pkg::ctrl_state_t state,
	output logic tx_wr_en,
	output api_cfg_pkg::word_t tx_din,
	input logic tx_full,
	input logic tx_empty,
	output logic rx_rd_en,
	input api_cfg_pkg::word_t rx_dout,
	input logic rx_empty,
	input api_cfg_pkg::fifo_cnt_t rx_count
);
	import api_cfg_pkg::*;
	import api_reg_pkg::*;

	logic wr_acc;
	logic rd_acc;
	word_t status;

	assign wr_acc = psel && penable && pwrite;
	assign rd_acc = psel && penable && !pwrite;
	assign pready = 1'b1; // no wait states.

	assign tx_din = pwdata;
	assign tx_wr_en = wr_acc && (paddr == reg_tx_data_addr) && !tx_full;
	assign rx_rd_en = rd_acc && (paddr == reg_rx_data_addr) && !rx_empty; // pop on access.
	assign pslverr = (wr_acc && (paddr == reg_tx_data_addr) && tx_full) ||
		(rd_acc && (paddr == reg_rx_data_addr) && rx_empty);

	always_comb begin
		status = '0;
		status[status_state_msb:status_state_lsb] = state;
		status[status_tx_empty_bit] = tx_empty;
		status[status_rx_count_msb:status_rx_count_lsb] = rx_count;
	end

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				reg_timeout_addr: prdata = word_t'(reg_timeout);
				reg_sck_addr: prdata = word_t'(reg_sck);
				reg_ch_num_addr: prdata = word_t'(reg_ch_num);
				reg_word_num_addr: prdata = word_t'(reg_word_num);
				reg_rx_data_addr: prdata = rx_dout;
				reg_status_addr: prdata = status;
				default: prdata = '0; // unknown address.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_timeout <= '0;
			reg_sck <= '0;
			reg_ch_num <= ch_t'(1);
			reg_word_num <= word_cnt_t'(work_len);
		end else if (wr_acc) begin
			case (paddr)
				reg_timeout_addr: reg_timeout <= timeout_t'(pwdata);
				reg_sck_addr: reg_sck <= sck_div_t'(pwdata);
				reg_ch_num_addr: reg_ch_num <= ch_t'(pwdata);
				reg_word_num_addr: reg_word_num <= word_cnt_t'(pwdata);
				default: ;
			endcase
		end
	end

endmodule

//--- api_top.sv
`timescale 1ns/1ns

module api_top (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input api_reg_pkg::addr_t paddr,
	input api_cfg_pkg::word_t pwdata,
	output api_cfg_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,
	output logic [api_cfg_pkg::api_num-1:0] load,
	output logic sck,
	output logic mosi,
	input logic [api_cfg_pkg::api_num-1:0] miso
);
	import api_cfg_pkg::*;

	timeout_t reg_timeout;
	sck_div_t reg_sck;
	ch_t reg_ch_num;
	word_cnt_t reg_word_num;
	ctrl_state_t state;
	logic tx_wr_en;
	word_t tx_din;
	logic tx_full;
	logic tx_empty;
	logic tx_rd_en;
	word_t tx_dout;
	logic rx_wr_en;
	word_t rx_din;
	logic rx_rd_en;
	word_t rx_dout;
	logic rx_empty;
	fifo_cnt_t rx_count;

	api_regs api_regs_inst (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.reg_timeout(reg_timeout),
		.reg_sck(reg_sck),
		.reg_ch_num(reg_ch_num),
		.reg_word_num(reg_word_num),
		.state(state),
		.tx_wr_en(tx_wr_en),
		.tx_din(tx_din),
		.tx_full(tx_full),
		.tx_empty(tx_empty),
		.rx_rd_en(rx_rd_en),
		.rx_dout(rx_dout),
		.rx_empty(rx_empty),
		.rx_count(rx_count)
	);

	api_fifo #(.depth(tx_depth)) tx_fifo_inst (
		.clk(clk),
		.rst(rst),
		.wr_en(tx_wr_en),
		.din(tx_din),
		.rd_en(tx_rd_en),
		.dout(tx_dout),
		.full(tx_full),
		.empty(tx_empty),
		.count()
	);

	api_fifo #(.depth(rx_depth)) rx_fifo_inst (
		.clk(clk),
		.rst(rst),
		.wr_en(rx_wr_en),
		.din(rx_din),
		.rd_en(rx_rd_en),
		.dout(rx_dout),
		.full(),
		.empty(rx_empty),
		.count(rx_count)
	);

	api_ctrl api_ctrl_inst (
		.clk(clk),
		.rst(rst),
		.reg_timeout(reg_timeout),
		.reg_sck(reg_sck),
		.reg_ch_num(reg_ch_num),
		.reg_word_num(reg_word_num),
		.state(state),
		.tx_empty(tx_empty),
		.tx_rd_en(tx_rd_en),
		.tx_dout(tx_dout),
		.rx_wr_en(rx_wr_en),
		.rx_din(rx_din),
		.rx_count(rx_count),
		.load(load),
		.sck(sck),
		.mosi(mosi),
		.miso(miso)
	);

endmodule

//--- tb_api.sv
`timescale 1ns/1ns

module tb_api;
	import api_cfg_pkg::*;
	import api_reg_pkg::*;

	localparam int poll_limit = 20000; // cycles without progress per wait.

	logic clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	addr_t paddr;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;
	logic [api_num-1:0] load;
	logic sck;
	logic mosi;
	logic [api_num-1:0] miso;

	integer seed = 86749;
	int cycle = 0;
	logic aborted = 1'b0;
	int errs = 0; // errors in the running test.
	int n_pass = 0;
	int n_fail = 0;
	string cur_mode;
	string cur_name;
	int cur_timeout;
	int cur_sck;
	int cur_ch;
	int cur_words;
	word_t cur_base;
	word_t tx_q[$];
	word_t exp_q[$];
	int file_tags[$];
	int model_tags[$];
	int load_seq[$]; // low load bit of every channel opened.
	logic multi_low = 1'b0;
	logic [api_num-1:0] prev_load;

	always #20 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	// the selected chip loops mosi back and the others read as one.
	assign miso = load | {api_num{mosi}};

	always @(negedge clk) begin
		if (!rst) begin
			if (load != prev_load && load != '1)
				for (int i = 0; i < api_num; i++)
					if (!load[i])
						load_seq.push_back(i);
			if ($countones(~load) > 1)
				multi_low = 1'b1;
		end
		prev_load <= load;
	end

	api_top api_top_inst (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.load(load),
		.sck(sck),
		.mosi(mosi),
		.miso(miso)
	);

	task automatic apb_write(input addr_t addr, input word_t data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		if (pready !== 1'b1)
			problem("pready was low in the access phase of a write");
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input addr_t addr, output word_t data, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata; // read data is combinational in the access phase.
		err = pslverr;
		if (pready !== 1'b1)
			problem("pready was low in the access phase of a read");
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic report_mismatch(input string what, input word_t exp, input word_t act);
		$display("** Error: %s %s: expected %h, actual %h", cur_name, what, exp, act);
		errs++;
	endtask

	task automatic problem(input string msg);
		$display("%s: %s", cur_name, msg);
		errs++;
	endtask

	task automatic timed_out(input string msg);
		$display("%s: timed out %s", cur_name, msg);
		errs++;
		aborted = 1'b1;
	endtask

	task automatic configure();
		logic err;
		apb_write(reg_timeout_addr, word_t'(cur_timeout), err);
		apb_write(reg_sck_addr, word_t'(cur_sck), err);
		apb_write(reg_ch_num_addr, word_t'(cur_ch), err);
		apb_write(reg_word_num_addr, word_t'(cur_words), err);
	endtask

	// reply words equal the sent words, so expected results follow from the job words.
	task automatic build_rounds(input int rounds, input bit rand_payload);
		word_t w;
		int k;
		tx_q.delete();
		exp_q.delete();
		model_tags.delete();
		for (int r = 0; r < rounds; r++) begin
			for (int c = 0; c < cur_ch; c++) begin
				for (int j = 0; j < cur_words; j++) begin
					w = rand_payload ? word_t'($random(seed)) : cur_base + word_t'(tx_q.size());
					tx_q.push_back(w);
					k = j % work_len;
					if (k == rx_block_len - 1) begin
						exp_q.push_back({w[31:16], tag_marker, 8'(c)});
						model_tags.push_back(int'({tag_marker, 8'(c)}));
					end else if (k < rx_block_len) begin
						exp_q.push_back(w);
					end
				end
			end
		end
	endtask

	// push job words and collect the results until every expected word has come back.
	task automatic exchange(input bit push);
		word_t st;
		word_t got;
		logic err;
		int tx_idx;
		int rx_idx;
		int start;
		tx_idx = push ? 0 : tx_q.size();
		rx_idx = 0;
		start = cycle;
		while (tx_idx < tx_q.size() || rx_idx < exp_q.size()) begin
			if (cycle - start > poll_limit) begin
				timed_out($sformatf("with %0d of %0d receive words", rx_idx, exp_q.size()));
				return;
			end
			if (tx_idx < tx_q.size()) begin
				apb_write(reg_tx_data_addr, tx_q[tx_idx], err);
				if (!err) begin
					tx_idx++;
					start = cycle;
				end
			end
			apb_read(reg_status_addr, st, err);
			if (st[status_rx_count_msb:status_rx_count_lsb] != 0) begin
				apb_read(reg_rx_data_addr, got, err);
				if (err)
					problem("rx_data read gave pslverr while words were pending");
				if (got !== exp_q[rx_idx])
					report_mismatch($sformatf("rx word %0d", rx_idx), exp_q[rx_idx], got);
				rx_idx++;
				start = cycle;
			end
		end
	endtask

	task automatic wait_idle(output int seen);
		word_t st;
		logic err;
		int start;
		seen = cycle;
		start = cycle;
		apb_read(reg_status_addr, st, err);
		while (st[status_state_msb:status_state_lsb] != idle) begin
			if (cycle - start > poll_limit) begin
				timed_out("waiting for the controller to return to idle");
				return;
			end
			apb_read(reg_status_addr, st, err);
		end
		seen = cycle;
	endtask

	task automatic finish_rounds(input int rounds);
		word_t st;
		logic err;
		if (aborted)
			return;
		apb_read(reg_status_addr, st, err);
		if (st[status_rx_count_msb:status_rx_count_lsb] != 0)
			problem("receive words left over after the round");
		if (st[status_tx_empty_bit] !== 1'b1)
			problem("transmit FIFO not empty after the round");
		if (load_seq.size() != rounds * cur_ch) begin
			report_mismatch("load selections", word_t'(rounds * cur_ch), word_t'(load_seq.size()));
		end else begin
			foreach (load_seq[i])
				if (load_seq[i] != i % cur_ch)
					report_mismatch($sformatf("low load bit %0d", i), word_t'(i % cur_ch),
						word_t'(load_seq[i]));
		end
		if (multi_low)
			problem("more than one load bit was low at once");
	endtask

	task automatic run_test();
		word_t st;
		word_t got;
		word_t exp_st;
		logic err;
		int t0;
		int t1;
		int kept;
		int start;
		errs = 0;
		load_seq.delete();
		model_tags.delete();
		multi_low = 1'b0;
		if (cur_mode == "reset") begin
			exp_st = '0;
			exp_st[status_tx_empty_bit] = 1'b1;
			apb_read(reg_status_addr, st, err);
			if (st !== exp_st)
				report_mismatch("status", exp_st, st);
			@(negedge clk);
			if (load !== '1)
				report_mismatch("load", word_t'({api_num{1'b1}}), word_t'(load));
			if (sck !== 1'b0 || mosi !== 1'b0)
				problem("sck or mosi not low after reset");
		end else if (cur_mode == "apberr") begin
			apb_read(reg_rx_data_addr, got, err);
			if (err !== 1'b1)
				problem("reading rx_data from an empty receive FIFO gave no pslverr");
			apb_read(8'h3C, got, err);
			if (got !== '0)
				report_mismatch("unknown address data", '0, got);
			if (err !== 1'b0)
				problem("unknown address gave pslverr");
		end else if (cur_mode == "round" || cur_mode == "timeout") begin
			configure();
			build_rounds(1, 1'b0);
			t0 = cycle;
			exchange(1'b1);
			if (!aborted)
				wait_idle(t1);
			finish_rounds(1);
			if (!aborted && cur_mode == "timeout" &&
				(t1 - t0 < cur_timeout || t1 - t0 > cur_timeout + 200))
				problem($sformatf("round took %0d cycles with a timeout of %0d", t1 - t0,
					cur_timeout));
		end else if (cur_mode == "backpressure") begin
			configure();
			build_rounds(2, 1'b1);
			kept = exp_q.size() / 2;
			foreach (tx_q[i]) begin
				apb_write(reg_tx_data_addr, tx_q[i], err);
				if (err)
					problem("transmit FIFO refused a job word");
			end
			start = cycle;
			apb_read(reg_status_addr, st, err);
			while (!(st[status_state_msb:status_state_lsb] == idle &&
				st[status_rx_count_msb:status_rx_count_lsb] == kept) && !aborted) begin
				if (cycle - start > poll_limit)
					timed_out("waiting for the first round to fill the receive FIFO");
				else
					apb_read(reg_status_addr, st, err);
			end
			repeat (200) @(posedge clk); // the second round has to stay stalled.
			apb_read(reg_status_addr, st, err);
			if (st[status_state_msb:status_state_lsb] != idle || st[status_tx_empty_bit])
				problem("second round did not stall in idle with job words waiting");
			if (st[status_rx_count_msb:status_rx_count_lsb] != kept)
				report_mismatch("stalled rx_count", word_t'(kept),
					word_t'(st[status_rx_count_msb:status_rx_count_lsb]));
			if (!aborted)
				exchange(1'b0);
			if (!aborted)
				wait_idle(t1);
			finish_rounds(2);
		end else begin
			problem($sformatf("unknown test mode %s", cur_mode));
		end
		if (file_tags.size() != model_tags.size()) begin
			report_mismatch("tag count", word_t'(model_tags.size()), word_t'(file_tags.size()));
		end else begin
			foreach (file_tags[i])
				if (file_tags[i] != model_tags[i])
					report_mismatch($sformatf("file tag %0d", i), word_t'(model_tags[i]),
						word_t'(file_tags[i]));
		end
		if (errs == 0) begin
			n_pass++;
			$display("test %s: ok", cur_name);
		end else begin
			n_fail++;
			$display("test %s: FAILED with %0d errors", cur_name, errs);
		end
	endtask

	initial begin
		int fd;
		int n;
		int tag;
		string kind;
		string line;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		fd = $fopen("api_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open api_tests.txt");
			aborted = 1'b1;
		end else begin
			while (!aborted && $fscanf(fd, "%s", kind) == 1) begin
				if (kind == "#") begin
					n = $fgets(line, fd);
				end else if (kind == "test") begin
					n = $fscanf(fd, "%s %s %d %d %d %d %h", cur_mode, cur_name, cur_timeout,
						cur_sck, cur_ch, cur_words, cur_base);
				end else if (kind == "tag") begin
					n = $fscanf(fd, "%h", tag);
					file_tags.push_back(tag);
				end else if (kind == "end") begin
					run_test();
					file_tags.delete();
				end else begin
					$display("unknown keyword %s in api_tests.txt", kind);
					aborted = 1'b1;
				end
			end
			$fclose(fd);
		end
		$display("tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0 && n_pass > 0 && !aborted)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- api_tests.txt
# test <mode> <name> <timeout> <sck_div> <ch_num> <word_num> <payload base, hex>
# tag <low half of each tag word, marker then channel, hex>; end closes a test
test reset after_reset 0 0 1 23 00000000
end
test round one_channel 0 0 1 23 12340000
tag 1200
end
test round three_channels 0 0 3 23 a5a50000
tag 1200
tag 1201
tag 1202
end
test backpressure rx_backpressure 0 0 1 23 00000000
tag 1200
tag 1200
end
test apberr apb_errors 0 0 1 23 00000000
end
test timeout round_timeout 2000 1 1 2 5a5a0000
end

//--- tb.f
api_cfg_pkg.sv
api_reg_pkg.sv
api_fifo.sv
api_timer.sv
api_phy.sv
api_ctrl.sv
api_regs.sv
api_top.sv
tb_api.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_api
./obj_dir/Vtb_api | tee sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
exit 0
